// ==== design/chan_buf_cfg.svh ====
// -----------------------------------------------
// channel buffer configuration
// sizes shared by the package and all RTL blocks
// -----------------------------------------------
`ifndef CHAN_BUF_CFG_SVH
`define CHAN_BUF_CFG_SVH

// number of channels, one lane FIFO each
// power of two
`define CB_NUM_CHAN   4

`define CB_DATA_W     16  // payload bits per word

// entries per lane, power of two, min 2
`define CB_LANE_DEPTH 4

`define CB_DROP_W     8   // saturating drop counter

`endif

// ==== design/chan_buf_pkg.sv ====
// -----------------------------------------------
// channel buffer package
// vector types shared across the RTL
// -----------------------------------------------
`include "chan_buf_cfg.svh"

package chan_buf_pkg;

    // channel number width, kept at least one bit wide
    localparam int CB_CHAN_W = ($clog2(`CB_NUM_CHAN) > 0) ? $clog2(`CB_NUM_CHAN) : 1;

    // ------------------------------------------------
    // payload and control vectors
    // ------------------------------------------------
    typedef logic [`CB_DATA_W-1:0]   word_t;       // one stream word
    typedef logic [CB_CHAN_W-1:0]    chan_id_t;    // channel tag
    typedef logic [`CB_NUM_CHAN-1:0] lane_mask_t;  // one bit per lane
    typedef logic [`CB_DROP_W-1:0]   drop_cnt_t;   // dropped word count

endpackage

// ==== design/lane_if.sv ====
// -----------------------------------------------
// lane interface
// write and read side of one lane FIFO
// -----------------------------------------------
interface lane_if
    import chan_buf_pkg::*;
();

    // write side
    logic  we;     // write enable, from dispatcher
    word_t wdata;  // write data
    logic  free;   // at least one entry free
    logic  half;   // level >= depth/2

    // read side
    logic  re;     // pop head entry
    logic  avail;  // head entry valid
    word_t rdata;  // head entry, async read

    // the FIFO itself
    modport fifo_mp (input we, wdata, re, output free, half, avail, rdata);

    // dispatcher side, sees only the space flag
    modport wr_mp (output we, wdata, input free);

    // drain side
    modport rd_mp (output re, input avail, rdata);

endinterface

// ==== design/lane_fifo.sv ====
// -----------------------------------------------
// lane FIFO
// single clock, async read, safe write/read gating
// -----------------------------------------------
`include "chan_buf_cfg.svh"

module lane_fifo
    import chan_buf_pkg::*;
#(
    parameter int DEPTH = `CB_LANE_DEPTH  // power of two, min 2
) (
    input  logic clk_i,    // rising edge
    input  logic rstn_i,   // async reset, low active
    input  logic clear_i,  // sync flush, high active
    lane_if.fifo_mp lane
);

    localparam int IDX_W = $clog2(DEPTH);

    typedef logic [IDX_W:0] ptr_t;  // index plus wrap bit

    word_t mem [DEPTH];  // storage without reset

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    ptr_t level;   // entries in use

    logic idx_match;
    logic full;
    logic empty;
    logic do_wr;   // accepted write
    logic do_rd;   // accepted read

    // config check ----------------------------------
    initial begin
        assert ((DEPTH >= 2) && ((DEPTH & (DEPTH - 1)) == 0))
        else $error("lane_fifo: DEPTH must be a power of two >= 2");
    end

    // access gating ---------------------------------
    assign do_wr = lane.we & ~full;   // write only with space left
    assign do_rd = lane.re & ~empty;  // read only with data present

    // pointers --------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (clear_i) begin
            wr_ptr <= '0;  // flush leaves stale contents behind
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // status ----------------------------------------
    // on equal index the wrap bit tells full from empty
    assign idx_match = (wr_ptr[IDX_W-1:0] == rd_ptr[IDX_W-1:0]);
    assign full      = idx_match & (wr_ptr[IDX_W] != rd_ptr[IDX_W]);
    assign empty     = idx_match & (wr_ptr[IDX_W] == rd_ptr[IDX_W]);

    assign level = wr_ptr - rd_ptr;  // wraps modulo 2*DEPTH

    assign lane.free  = ~full;
    assign lane.avail = ~empty;
    assign lane.half  = (level >= ptr_t'(DEPTH / 2));

    // memory ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr[IDX_W-1:0]] <= lane.wdata;
        end
    end

    // head entry visible as soon as avail rises
    assign lane.rdata = mem[rd_ptr[IDX_W-1:0]];

    // checks ----------------------------------------
    // a write racing a full lane from the dispatcher must not push the level past depth
    a_level_max : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        level <= ptr_t'(DEPTH)
    ) else $error("lane_fifo: level above DEPTH");

    // flags agree with the pointer distance
    a_flags_consistent : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (full -> (lane.avail && (level == ptr_t'(DEPTH)))) and
        (!lane.avail -> (level == '0))
    ) else $error("lane_fifo: status flags disagree with pointers");

endmodule

// ==== design/chan_dispatch.sv ====
// -----------------------------------------------
// channel dispatcher
// steers input strobes to lanes, counts drops
// -----------------------------------------------
`include "chan_buf_cfg.svh"

module chan_dispatch
    import chan_buf_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      clear_i,
    input  logic      in_valid_i,   // one-cycle strobe
    input  chan_id_t  in_chan_i,    // target lane
    input  word_t     in_data_i,
    lane_if.wr_mp     lanes [`CB_NUM_CHAN],
    output drop_cnt_t drop_cnt_o    // saturating
);

    lane_mask_t we_mask;    // decoded write enables
    lane_mask_t free_mask;  // lane space flags
    logic       drop;       // strobe hits a full lane

    // per lane decode -------------------------------
    for (genvar k = 0; k < `CB_NUM_CHAN; k++) begin : g_lane
        assign we_mask[k]     = in_valid_i & (in_chan_i == chan_id_t'(k));
        assign lanes[k].we    = we_mask[k];
        assign lanes[k].wdata = in_data_i;  // broadcast, we picks the lane
        assign free_mask[k]   = lanes[k].free;
    end

    assign drop = in_valid_i & ~free_mask[in_chan_i];

    // drop counter ----------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            drop_cnt_o <= '0;
        end else if (clear_i) begin
            drop_cnt_o <= '0;
        end else if (drop && (drop_cnt_o != '1)) begin
            drop_cnt_o <= drop_cnt_o + 1'b1;  // hold at max
        end
    end

    // single writer per cycle across the lane array
    a_we_onehot : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        $onehot0(we_mask)
    ) else $error("chan_dispatch: more than one lane write");

endmodule

// ==== design/rr_drain.sv ====
// -----------------------------------------------
// round-robin drain
// pops non-empty lanes into a valid/ready register
// -----------------------------------------------
`include "chan_buf_cfg.svh"

module rr_drain
    import chan_buf_pkg::*;
(
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     clear_i,
    lane_if.rd_mp    lanes [`CB_NUM_CHAN],
    output logic     out_valid_o,
    output chan_id_t out_chan_o,
    output word_t    out_data_o,
    input  logic     out_ready_i
);

    localparam int NUM = `CB_NUM_CHAN;

    lane_mask_t avail_mask;        // lanes holding data
    lane_mask_t re_mask;           // pops this cycle
    word_t      lane_data [NUM];   // head words
    chan_id_t   last_q;            // last granted lane
    chan_id_t   grant;
    logic       found;             // some lane wins
    logic       reg_free;          // output reg can take a word
    logic       load;

    // gather lane status ----------------------------
    for (genvar k = 0; k < NUM; k++) begin : g_lane
        assign avail_mask[k] = lanes[k].avail;
        assign lane_data[k]  = lanes[k].rdata;
        assign re_mask[k]    = load & (grant == chan_id_t'(k));
        assign lanes[k].re   = re_mask[k];
    end

    // rotating priority, starts after last grant
    always_comb begin : rr_pick
        chan_id_t cand;
        grant = last_q;
        found = 1'b0;
        for (int i = 1; i <= NUM; i++) begin
            cand = chan_id_t'(last_q + i);  // wraps, NUM is a power of two
            if (!found && avail_mask[cand]) begin
                grant = cand;
                found = 1'b1;
            end
        end
    end

    assign reg_free = ~out_valid_o | out_ready_i;  // empty or leaving now
    assign load     = reg_free & found;

    // output register -------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            out_valid_o <= 1'b0;
            last_q      <= chan_id_t'(NUM - 1);  // lane 0 first
        end else if (clear_i) begin
            out_valid_o <= 1'b0;
            last_q      <= chan_id_t'(NUM - 1);
        end else if (load) begin
            out_valid_o <= 1'b1;
            last_q      <= grant;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;  // transferred, nothing new
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            out_data_o <= lane_data[grant];
            out_chan_o <= grant;
        end
    end

    // checks ----------------------------------------
    a_re_onehot : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        $onehot0(re_mask)
    ) else $error("rr_drain: more than one lane popped");

    // stalled word must not change or vanish
    a_hold_stall : assert property (
        @(posedge clk_i) disable iff (!rstn_i || clear_i)
        (out_valid_o && !out_ready_i) |=>
            (out_valid_o && $stable(out_data_o) && $stable(out_chan_o))
    ) else $error("rr_drain: output changed while stalled");

endmodule

// ==== design/chan_buf_top.sv ====
// -----------------------------------------------
// multi-channel stream buffer, top level
// -----------------------------------------------
`include "chan_buf_cfg.svh"

module chan_buf_top
    import chan_buf_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,       // async, low active
    input  logic       clear_i,      // sync flush
    // input stream, no back-pressure
    input  logic       in_valid_i,
    input  chan_id_t   in_chan_i,
    input  word_t      in_data_i,
    // output stream
    output logic       out_valid_o,
    output chan_id_t   out_chan_o,
    output word_t      out_data_o,
    input  logic       out_ready_i,
    // status
    output lane_mask_t lane_half_o,  // per-lane half-full
    output drop_cnt_t  drop_cnt_o
);

    lane_if lanes [`CB_NUM_CHAN] ();  // element k is lane k

    chan_dispatch u_dispatch (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .clear_i    (clear_i),
        .in_valid_i (in_valid_i),
        .in_chan_i  (in_chan_i),
        .in_data_i  (in_data_i),
        .lanes      (lanes),
        .drop_cnt_o (drop_cnt_o)
    );

    // lane FIFOs ------------------------------------
    for (genvar k = 0; k < `CB_NUM_CHAN; k++) begin : g_lane
        lane_fifo #(
            .DEPTH (`CB_LANE_DEPTH)
        ) u_lane_fifo (
            .clk_i   (clk_i),
            .rstn_i  (rstn_i),
            .clear_i (clear_i),
            .lane    (lanes[k])
        );
        assign lane_half_o[k] = lanes[k].half;
    end

    rr_drain u_drain (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .clear_i     (clear_i),
        .lanes       (lanes),
        .out_valid_o (out_valid_o),
        .out_chan_o  (out_chan_o),
        .out_data_o  (out_data_o),
        .out_ready_i (out_ready_i)
    );

endmodule

// ==== testbench/tb_chan_buf.sv ====
// -----------------------------------------------
// testbench for the multi-channel stream buffer
// per-channel reference queues, negedge comparator
// -----------------------------------------------
`include "chan_buf_cfg.svh"

module tb_chan_buf
    import chan_buf_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM         = `CB_NUM_CHAN;
    localparam int DEPTH       = `CB_LANE_DEPTH;
    localparam int DROP_MAX    = (1 << `CB_DROP_W) - 1;
    localparam int CLK_PERIOD  = 20;
    localparam int RAND_CYCLES = 200;
    localparam int DRAIN_LIMIT = NUM * (DEPTH + 1) * 4 + 20;
    // rough length of all tests in cycles
    localparam int STIM_CYCLES = NUM * 10 + RAND_CYCLES + (DEPTH + 1) * (DEPTH + 12) + 60;

    logic clk_i, rstn_i, clear_i, in_valid_i, out_ready_i, out_valid_o;
    chan_id_t   in_chan_i, out_chan_o;
    word_t      in_data_i, out_data_o;
    lane_mask_t lane_half_o;
    drop_cnt_t  drop_cnt_o;

    word_t    exp_q [NUM][$];  // accepted words per channel
    chan_id_t log_chan [$];    // every word that left the DUT
    word_t    log_data [$];
    int model_drops = 0;
    int n_errors = 0;          // main process checks
    int mon_errors = 0;        // comparator checks
    int n_words = 0, n_tests = 0, n_failed = 0, err0 = 0, log_base = 0;
    int seed = 32'h548e128d;

    chan_buf_top u_chan_buf_top (.*);

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin : watchdog
        #((STIM_CYCLES * 4 + 200) * CLK_PERIOD);
        $display("watchdog expired, the run did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // head of a channel's reference queue
    function automatic word_t expect_word(input chan_id_t c);
        return exp_q[c][0];
    endfunction

    function automatic int pending();
        int sum = 0;
        for (int k = 0; k < NUM; k++) sum += exp_q[k].size();
        return sum;
    endfunction

    // comparator ------------------------------------
    // values at negedge are what the next rising edge samples
    always @(negedge clk_i) begin : monitor
        int       lane_lvl;
        chan_id_t ic;
        chan_id_t oc;
        if (rstn_i) begin
            if (drop_cnt_o !== drop_cnt_t'(model_drops)) begin
                $display("[ERROR] drop_cnt_o: got 0x%0h, expected 0x%0h", drop_cnt_o, model_drops);
                mon_errors++;
            end
            if (clear_i) begin
                for (int k = 0; k < NUM; k++) exp_q[k].delete();
                model_drops = 0;
            end else begin
                ic       = in_chan_i;
                lane_lvl = exp_q[ic].size();       // lane plus output reg
                if (out_valid_o && out_chan_o == ic) lane_lvl--;
                if (out_valid_o && out_ready_i) begin
                    oc = out_chan_o;
                    if (exp_q[oc].size() == 0) begin
                        $display("unexpected word 0x%0h on channel %0d", out_data_o, oc);
                        mon_errors++;
                    end else begin
                        if (out_data_o !== expect_word(oc)) begin
                            $display("[ERROR] out_data_o: got 0x%0h, expected 0x%0h",
                                     out_data_o, expect_word(oc));
                            mon_errors++;
                        end
                        void'(exp_q[oc].pop_front());
                    end
                    log_chan.push_back(oc);
                    log_data.push_back(out_data_o);
                    n_words++;
                end
                if (in_valid_i) begin
                    if (lane_lvl < DEPTH) exp_q[ic].push_back(in_data_i);
                    else if (model_drops < DROP_MAX) model_drops++;  // saturates
                end
            end
        end
    end

    // helpers ---------------------------------------
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        n_errors++;
    endtask

    task automatic report_fail(input string what);
        $display("%s", what);
        n_errors++;
    endtask

    task automatic start_test();
        err0     = n_errors + mon_errors;
        log_base = log_data.size();
    endtask

    task automatic close_test(input string name);
        n_tests++;
        if (n_errors + mon_errors != err0) begin
            n_failed++;
            $display("test %0d %s: FAIL", n_tests, name);
        end else begin
            $display("test %0d %s: ok", n_tests, name);
        end
    endtask

    task automatic strobe(input chan_id_t c, input word_t d);
        @(posedge clk_i);
        in_valid_i <= 1'b1;
        in_chan_i  <= c;
        in_data_i  <= d;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            in_valid_i <= 1'b0;
        end
    endtask

    task automatic set_ready(input logic v);
        @(posedge clk_i);
        in_valid_i  <= 1'b0;
        out_ready_i <= v;
    endtask

    task automatic wait_drained();
        int cnt = 0;
        bit done = 1'b0;
        while (!done && cnt < DRAIN_LIMIT) begin
            @(negedge clk_i);
            cnt++;
            if (!out_valid_o && pending() == 0) done = 1'b1;
        end
        if (!done) report_fail("timeout waiting for the buffer to drain");
    endtask

    // test sequence ---------------------------------
    initial begin : main
        chan_id_t   c;
        word_t      d;
        word_t      sent [$];
        lane_mask_t exp_half;
        int         lat;
        logic [31:0] r;
        rstn_i      = 1'b0;
        clear_i     = 1'b0;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b0;
        in_chan_i   = '0;
        in_data_i   = '0;
        repeat (3) @(posedge clk_i);
        rstn_i <= 1'b1;
        idle(2);

        // one word per channel with a latency of two edges
        start_test();
        set_ready(1'b1);
        for (int k = 0; k < NUM; k++) begin
            c = chan_id_t'(k);
            strobe(c, word_t'(32'h1000 + k));
            @(posedge clk_i);              // edge t takes the strobe
            in_valid_i <= 1'b0;
            lat = 0;
            do begin
                @(negedge clk_i);
                lat++;
            end while (!out_valid_o && lat < 8);
            if (lat != 2) report_mismatch("out_valid_o latency", lat, 32'd2);
            if (out_chan_o !== c) report_mismatch("out_chan_o", 32'(out_chan_o), 32'(c));
            wait_drained();
        end
        close_test("single word");

        start_test();
        for (int i = 0; i < RAND_CYCLES; i++) begin
            r = $random(seed);
            if (r[0]) strobe(chan_id_t'(r >> 8), word_t'(r >> 16));
            else idle(1);
        end
        idle(1);
        wait_drained();
        if (pending() != 0) report_fail("reference queues not empty after random traffic");
        close_test("random traffic");

        // stalled lane holds DEPTH+1 and drops the rest
        start_test();
        set_ready(1'b0);
        c = chan_id_t'(NUM - 1);
        for (int i = 0; i < DEPTH + 3; i++) begin
            d = word_t'($random(seed));
            sent.push_back(d);
            strobe(c, d);
        end
        idle(3);
        @(negedge clk_i);
        if (drop_cnt_o !== drop_cnt_t'(2)) report_mismatch("drop_cnt_o", 32'(drop_cnt_o), 32'd2);
        set_ready(1'b1);
        wait_drained();
        if (log_data.size() - log_base != DEPTH + 1) begin
            report_fail($sformatf("%0d words left the buffer, %0d expected",
                                  log_data.size() - log_base, DEPTH + 1));
        end else begin
            for (int i = 0; i <= DEPTH; i++) begin
                if (log_data[log_base + i] !== sent[i])
                    report_mismatch("out_data_o", 32'(log_data[log_base + i]), 32'(sent[i]));
            end
        end
        close_test("overflow");

        start_test();
        c = chan_id_t'(1);
        for (int k = 1; k <= DEPTH + 1; k++) begin
            set_ready(1'b0);
            for (int i = 0; i < k; i++) strobe(c, word_t'($random(seed)));
            idle(3);
            @(negedge clk_i);
            exp_half = '0;
            if (k - 1 >= DEPTH / 2) exp_half[c] = 1'b1;   // one word sits in the output reg
            if (lane_half_o !== exp_half)
                report_mismatch("lane_half_o", 32'(lane_half_o), 32'(exp_half));
            set_ready(1'b1);
            wait_drained();
        end
        close_test("half full");

        // equal load per lane gives a strict rotation
        start_test();
        set_ready(1'b0);
        for (int k = 0; k < NUM; k++) begin
            strobe(chan_id_t'(k), word_t'($random(seed)));
            strobe(chan_id_t'(k), word_t'($random(seed)));
        end
        idle(3);
        set_ready(1'b1);
        wait_drained();
        if (log_chan.size() - log_base != 2 * NUM) begin
            report_fail("fairness test lost or added words");
        end else begin
            for (int i = 0; i < 2 * NUM; i++) begin
                c = chan_id_t'(i);  // lane 0 reached the empty output reg first
                if (log_chan[log_base + i] !== c)
                    report_mismatch("out_chan_o", 32'(log_chan[log_base + i]), 32'(c));
            end
        end
        close_test("fairness");

        start_test();
        set_ready(1'b0);
        for (int i = 0; i < DEPTH + 2; i++) strobe(chan_id_t'(0), word_t'($random(seed)));
        strobe(chan_id_t'(NUM - 1), word_t'($random(seed)));
        idle(2);
        @(posedge clk_i);
        clear_i <= 1'b1;
        @(posedge clk_i);
        clear_i <= 1'b0;
        @(negedge clk_i);
        if (out_valid_o !== 1'b0) report_mismatch("out_valid_o", 32'(out_valid_o), 32'd0);
        if (drop_cnt_o !== '0) report_mismatch("drop_cnt_o", 32'(drop_cnt_o), 32'd0);
        if (lane_half_o !== '0) report_mismatch("lane_half_o", 32'(lane_half_o), 32'd0);
        set_ready(1'b1);
        idle(10);
        if (log_data.size() != log_base) report_fail("old words appeared after clear");
        for (int k = 0; k < NUM; k++) strobe(chan_id_t'(k), word_t'(32'hc0 + k));
        idle(1);
        wait_drained();
        if (log_data.size() - log_base != NUM) report_fail("fresh words lost after clear");
        close_test("clear");

        $display("summary: %0d tests, %0d failed, %0d words compared, %0d errors",
                 n_tests, n_failed, n_words, n_errors + mon_errors);
        if (n_errors + mon_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+design
design/chan_buf_pkg.sv
design/lane_if.sv
design/lane_fifo.sv
design/chan_dispatch.sv
design/rr_drain.sv
design/chan_buf_top.sv
testbench/tb_chan_buf.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the channel buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_chan_buf -Mdir obj_dir -o sim_chan_buf

./obj_dir/sim_chan_buf | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
